/* hdl/dispatch_pkg.sv */
`default_nettype none

package dispatch_pkg;

  localparam int unsigned WORD_W = 32;
  localparam int unsigned REG_IDX_W = 5;
  localparam int unsigned UID_W = 8;
  localparam int unsigned BYP_W = 3;

  // data word, register values, pc, immediates and results
  typedef logic [WORD_W-1:0] word_t;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // write-back unique id, wraps at 256
  typedef logic [UID_W-1:0] uid_t;

  // one-hot forward select per operand
  // bit 0 ex0, bit 1 ex1, bit 2 lsu, zero keeps the registered operand
  typedef logic [BYP_W-1:0] byp_sel_t;

  typedef enum logic [2:0] {
    CLS_ALU_REG,
    CLS_ALU_IMM,
    CLS_LUI,
    CLS_AUIPC,
    CLS_LOAD,
    CLS_STORE,
    CLS_MULDIV,
    CLS_BRANCH
  } op_class_t;

endpackage

`default_nettype wire

/* hdl/lane_operand_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_operand_reg (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   v_i,
  input  dispatch_pkg::op_class_t class_i,
  input  dispatch_pkg::reg_idx_t rd_i,
  input  dispatch_pkg::word_t    pc_i,
  input  dispatch_pkg::word_t    imm_i,
  input  dispatch_pkg::word_t    rs1_i,
  input  dispatch_pkg::word_t    rs2_i,
  input  dispatch_pkg::byp_sel_t byp1_i,
  input  dispatch_pkg::byp_sel_t byp2_i,
  input  logic                   branch_ex_i,
  output logic                   v_o,
  output dispatch_pkg::op_class_t class_o,
  output dispatch_pkg::reg_idx_t rd_o,
  output dispatch_pkg::word_t    op1_o,
  output dispatch_pkg::word_t    op2_o,
  output dispatch_pkg::word_t    addr_o,
  output dispatch_pkg::byp_sel_t byp1_o,
  output dispatch_pkg::byp_sel_t byp2_o
);
  import dispatch_pkg::*;

  logic  accept;
  word_t op1_d;
  word_t op2_d;

  // a taken branch in execute kills the incoming pair
  assign accept = v_i & ~branch_ex_i;

  // operand selection by instruction class
  always_comb begin
    op1_d = rs1_i;
    op2_d = rs2_i;
    case (class_i)
      CLS_ALU_IMM, CLS_LOAD: begin
        op2_d = imm_i;
      end
      CLS_LUI: begin
        op1_d = '0;
        op2_d = imm_i;
      end
      CLS_AUIPC: begin
        op1_d = pc_i;
        op2_d = imm_i;
      end
      default: begin
        op1_d = rs1_i;
        op2_d = rs2_i;
      end
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      v_o <= 1'b0;
    end else begin
      v_o <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      class_o <= class_i;
      rd_o    <= rd_i;
      op1_o   <= op1_d;
      op2_o   <= op2_d;
      // load/store address, computed for every class
      addr_o  <= rs1_i + imm_i;
      byp1_o  <= byp1_i;
      byp2_o  <= byp2_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/issue_router.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_router (
  input  logic                    lane0_v_i,
  input  dispatch_pkg::op_class_t lane0_class_i,
  input  logic                    lane1_v_i,
  input  dispatch_pkg::op_class_t lane1_class_i,
  input  logic                    branch_ex_i,
  output logic                    ex0_v_o,
  output logic                    ex1_v_o,
  output logic                    ld_v_o,
  output logic                    st_v_o,
  output logic                    mu_v_o,
  output logic                    lsu_sel_o,
  output logic                    mu_sel_o,
  output logic                    any_v_o
);
  import dispatch_pkg::*;

  logic go;
  logic ld0;
  logic ld1;
  logic st0;
  logic st1;
  logic mu0;
  logic mu1;

  // single flush gate for every unit
  assign go = ~branch_ex_i;

  assign ld0 = lane0_v_i & (lane0_class_i == CLS_LOAD);
  assign ld1 = lane1_v_i & (lane1_class_i == CLS_LOAD);
  assign st0 = lane0_v_i & (lane0_class_i == CLS_STORE);
  assign st1 = lane1_v_i & (lane1_class_i == CLS_STORE);
  assign mu0 = lane0_v_i & (lane0_class_i == CLS_MULDIV);
  assign mu1 = lane1_v_i & (lane1_class_i == CLS_MULDIV);

  // everything else is plain alu work on the lane's own unit
  assign ex0_v_o = go & lane0_v_i & ~ld0 & ~st0 & ~mu0;
  assign ex1_v_o = go & lane1_v_i & ~ld1 & ~st1 & ~mu1;

  // upstream sends at most one memory op and one muldiv per pair
  assign ld_v_o = go & (ld0 | ld1);
  assign st_v_o = go & (st0 | st1);
  assign mu_v_o = go & (mu0 | mu1);

  assign lsu_sel_o = ld1 | st1;
  assign mu_sel_o  = mu1;

  assign any_v_o = go & (lane0_v_i | lane1_v_i);

endmodule

`default_nettype wire

/* hdl/bypass_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module bypass_mux (
  input  logic                   lsu_sel_i,
  input  logic                   mu_sel_i,
  input  dispatch_pkg::word_t    rst_ex0_i,
  input  dispatch_pkg::word_t    rst_ex1_i,
  input  dispatch_pkg::word_t    rst_lsu_i,
  input  dispatch_pkg::word_t    lane0_op1_i,
  input  dispatch_pkg::word_t    lane0_op2_i,
  input  dispatch_pkg::byp_sel_t lane0_byp1_i,
  input  dispatch_pkg::byp_sel_t lane0_byp2_i,
  input  dispatch_pkg::word_t    lane1_op1_i,
  input  dispatch_pkg::word_t    lane1_op2_i,
  input  dispatch_pkg::byp_sel_t lane1_byp1_i,
  input  dispatch_pkg::byp_sel_t lane1_byp2_i,
  output dispatch_pkg::word_t    ex0_op1_o,
  output dispatch_pkg::word_t    ex0_op2_o,
  output dispatch_pkg::word_t    ex1_op1_o,
  output dispatch_pkg::word_t    ex1_op2_o,
  output dispatch_pkg::word_t    mu_op1_o,
  output dispatch_pkg::word_t    mu_op2_o,
  output dispatch_pkg::word_t    lsu_op1_o,
  output dispatch_pkg::word_t    lsu_op2_o
);
  import dispatch_pkg::*;

  word_t fw0_op1;
  word_t fw0_op2;
  word_t fw1_op1;
  word_t fw1_op2;

  // and-or forwarding, select is one-hot so no priority needed
  function automatic word_t fwd(input byp_sel_t sel, input word_t op,
                                input word_t r_ex0, input word_t r_ex1,
                                input word_t r_lsu);
    fwd = ({$bits(word_t){sel[0]}} & r_ex0)
        | ({$bits(word_t){sel[1]}} & r_ex1)
        | ({$bits(word_t){sel[2]}} & r_lsu)
        | ({$bits(word_t){~|sel}}  & op);
  endfunction

  assign fw0_op1 = fwd(lane0_byp1_i, lane0_op1_i, rst_ex0_i, rst_ex1_i, rst_lsu_i);
  assign fw0_op2 = fwd(lane0_byp2_i, lane0_op2_i, rst_ex0_i, rst_ex1_i, rst_lsu_i);
  assign fw1_op1 = fwd(lane1_byp1_i, lane1_op1_i, rst_ex0_i, rst_ex1_i, rst_lsu_i);
  assign fw1_op2 = fwd(lane1_byp2_i, lane1_op2_i, rst_ex0_i, rst_ex1_i, rst_lsu_i);

  assign ex0_op1_o = fw0_op1;
  assign ex0_op2_o = fw0_op2;
  assign ex1_op1_o = fw1_op1;
  assign ex1_op2_o = fw1_op2;

  // mu and lsu follow whichever lane carries them
  assign mu_op1_o  = mu_sel_i ? fw1_op1 : fw0_op1;
  assign mu_op2_o  = mu_sel_i ? fw1_op2 : fw0_op2;
  assign lsu_op1_o = lsu_sel_i ? fw1_op1 : fw0_op1;
  assign lsu_op2_o = lsu_sel_i ? fw1_op2 : fw0_op2;

endmodule

`default_nettype wire

/* hdl/uid_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module uid_alloc (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    any_v_i,
  input  logic                    lane0_v_i,
  input  logic                    lane1_v_i,
  input  dispatch_pkg::op_class_t lane0_class_i,
  input  dispatch_pkg::op_class_t lane1_class_i,
  input  dispatch_pkg::reg_idx_t  lane0_rd_i,
  input  dispatch_pkg::reg_idx_t  lane1_rd_i,
  input  logic                    lsu_sel_i,
  input  logic                    mu_sel_i,
  output dispatch_pkg::uid_t      ex0_uid_o,
  output dispatch_pkg::uid_t      ex1_uid_o,
  output dispatch_pkg::uid_t      mu_uid_o,
  output dispatch_pkg::uid_t      lsu_uid_o,
  output logic [1:0]              uid_we_o
);
  import dispatch_pkg::*;

  uid_t uid_q;
  uid_t uid0;
  uid_t uid1;

  // stores and branches never write a register, nor does x0
  function automatic logic writes_rd(input op_class_t cls, input reg_idx_t rd);
    writes_rd = (cls != CLS_STORE) && (cls != CLS_BRANCH) && (rd != '0);
  endfunction

  assign uid0 = uid_q;
  assign uid1 = uid_q + uid_t'(lane0_v_i);

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      uid_q <= '0;
    end else if (any_v_i) begin
      uid_q <= uid_q + uid_t'(lane0_v_i) + uid_t'(lane1_v_i);
    end
  end

  assign ex0_uid_o = uid0;
  assign ex1_uid_o = uid1;
  assign mu_uid_o  = mu_sel_i ? uid1 : uid0;
  assign lsu_uid_o = lsu_sel_i ? uid1 : uid0;

  assign uid_we_o[0] = any_v_i & lane0_v_i & writes_rd(lane0_class_i, lane0_rd_i);
  assign uid_we_o[1] = any_v_i & lane1_v_i & writes_rd(lane1_class_i, lane1_rd_i);

endmodule

`default_nettype wire

/* hdl/dispatch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_top (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    lane0_v_i,
  input  dispatch_pkg::op_class_t lane0_class_i,
  input  dispatch_pkg::reg_idx_t  lane0_rd_i,
  input  dispatch_pkg::word_t     lane0_pc_i,
  input  dispatch_pkg::word_t     lane0_imm_i,
  input  dispatch_pkg::word_t     lane0_rs1_i,
  input  dispatch_pkg::word_t     lane0_rs2_i,
  input  dispatch_pkg::byp_sel_t  lane0_byp1_i,
  input  dispatch_pkg::byp_sel_t  lane0_byp2_i,
  input  logic                    lane1_v_i,
  input  dispatch_pkg::op_class_t lane1_class_i,
  input  dispatch_pkg::reg_idx_t  lane1_rd_i,
  input  dispatch_pkg::word_t     lane1_pc_i,
  input  dispatch_pkg::word_t     lane1_imm_i,
  input  dispatch_pkg::word_t     lane1_rs1_i,
  input  dispatch_pkg::word_t     lane1_rs2_i,
  input  dispatch_pkg::byp_sel_t  lane1_byp1_i,
  input  dispatch_pkg::byp_sel_t  lane1_byp2_i,
  input  logic                    branch_ex_i,
  input  dispatch_pkg::word_t     rst_ex0_i,
  input  dispatch_pkg::word_t     rst_ex1_i,
  input  dispatch_pkg::word_t     rst_lsu_i,
  output logic                    ex0_v_o,
  output dispatch_pkg::op_class_t ex0_class_o,
  output dispatch_pkg::reg_idx_t  ex0_rd_o,
  output dispatch_pkg::word_t     ex0_op1_o,
  output dispatch_pkg::word_t     ex0_op2_o,
  output dispatch_pkg::uid_t      ex0_uid_o,
  output logic                    ex1_v_o,
  output dispatch_pkg::op_class_t ex1_class_o,
  output dispatch_pkg::reg_idx_t  ex1_rd_o,
  output dispatch_pkg::word_t     ex1_op1_o,
  output dispatch_pkg::word_t     ex1_op2_o,
  output dispatch_pkg::uid_t      ex1_uid_o,
  output logic                    mu_v_o,
  output dispatch_pkg::op_class_t mu_class_o,
  output dispatch_pkg::reg_idx_t  mu_rd_o,
  output dispatch_pkg::word_t     mu_op1_o,
  output dispatch_pkg::word_t     mu_op2_o,
  output dispatch_pkg::uid_t      mu_uid_o,
  output logic                    ld_v_o,
  output logic                    st_v_o,
  output dispatch_pkg::reg_idx_t  lsu_rd_o,
  output dispatch_pkg::word_t     lsu_op1_o,
  output dispatch_pkg::word_t     lsu_op2_o,
  output dispatch_pkg::word_t     lsu_addr_o,
  output dispatch_pkg::uid_t      lsu_uid_o,
  output logic [1:0]              uid_we_o
);
  import dispatch_pkg::*;

  logic      l0_v;
  logic      l1_v;
  op_class_t l0_class;
  op_class_t l1_class;
  reg_idx_t  l0_rd;
  reg_idx_t  l1_rd;
  word_t     l0_op1;
  word_t     l0_op2;
  word_t     l1_op1;
  word_t     l1_op2;
  word_t     l0_addr;
  word_t     l1_addr;
  byp_sel_t  l0_byp1;
  byp_sel_t  l0_byp2;
  byp_sel_t  l1_byp1;
  byp_sel_t  l1_byp2;
  logic      lsu_sel;
  logic      mu_sel;
  logic      any_v;

  lane_operand_reg u_lane0 (
    .clk(clk), .resetn(resetn), .v_i(lane0_v_i), .class_i(lane0_class_i),
    .rd_i(lane0_rd_i), .pc_i(lane0_pc_i), .imm_i(lane0_imm_i),
    .rs1_i(lane0_rs1_i), .rs2_i(lane0_rs2_i), .byp1_i(lane0_byp1_i),
    .byp2_i(lane0_byp2_i), .branch_ex_i(branch_ex_i),
    .v_o(l0_v), .class_o(l0_class), .rd_o(l0_rd), .op1_o(l0_op1), .op2_o(l0_op2),
    .addr_o(l0_addr), .byp1_o(l0_byp1), .byp2_o(l0_byp2)
  );

  lane_operand_reg u_lane1 (
    .clk(clk), .resetn(resetn), .v_i(lane1_v_i), .class_i(lane1_class_i),
    .rd_i(lane1_rd_i), .pc_i(lane1_pc_i), .imm_i(lane1_imm_i),
    .rs1_i(lane1_rs1_i), .rs2_i(lane1_rs2_i), .byp1_i(lane1_byp1_i),
    .byp2_i(lane1_byp2_i), .branch_ex_i(branch_ex_i),
    .v_o(l1_v), .class_o(l1_class), .rd_o(l1_rd), .op1_o(l1_op1), .op2_o(l1_op2),
    .addr_o(l1_addr), .byp1_o(l1_byp1), .byp2_o(l1_byp2)
  );

  issue_router u_router (
    .lane0_v_i(l0_v), .lane0_class_i(l0_class), .lane1_v_i(l1_v),
    .lane1_class_i(l1_class), .branch_ex_i(branch_ex_i),
    .ex0_v_o(ex0_v_o), .ex1_v_o(ex1_v_o), .ld_v_o(ld_v_o), .st_v_o(st_v_o),
    .mu_v_o(mu_v_o), .lsu_sel_o(lsu_sel), .mu_sel_o(mu_sel), .any_v_o(any_v)
  );

  bypass_mux u_bypass (
    .lsu_sel_i(lsu_sel), .mu_sel_i(mu_sel),
    .rst_ex0_i(rst_ex0_i), .rst_ex1_i(rst_ex1_i), .rst_lsu_i(rst_lsu_i),
    .lane0_op1_i(l0_op1), .lane0_op2_i(l0_op2),
    .lane0_byp1_i(l0_byp1), .lane0_byp2_i(l0_byp2),
    .lane1_op1_i(l1_op1), .lane1_op2_i(l1_op2),
    .lane1_byp1_i(l1_byp1), .lane1_byp2_i(l1_byp2),
    .ex0_op1_o(ex0_op1_o), .ex0_op2_o(ex0_op2_o),
    .ex1_op1_o(ex1_op1_o), .ex1_op2_o(ex1_op2_o),
    .mu_op1_o(mu_op1_o), .mu_op2_o(mu_op2_o),
    .lsu_op1_o(lsu_op1_o), .lsu_op2_o(lsu_op2_o)
  );

  uid_alloc u_uid (
    .clk(clk), .resetn(resetn), .any_v_i(any_v),
    .lane0_v_i(l0_v), .lane1_v_i(l1_v),
    .lane0_class_i(l0_class), .lane1_class_i(l1_class),
    .lane0_rd_i(l0_rd), .lane1_rd_i(l1_rd),
    .lsu_sel_i(lsu_sel), .mu_sel_i(mu_sel),
    .ex0_uid_o(ex0_uid_o), .ex1_uid_o(ex1_uid_o),
    .mu_uid_o(mu_uid_o), .lsu_uid_o(lsu_uid_o), .uid_we_o(uid_we_o)
  );

  // control fields of the lane each unit serves
  assign ex0_class_o = l0_class;
  assign ex0_rd_o    = l0_rd;
  assign ex1_class_o = l1_class;
  assign ex1_rd_o    = l1_rd;
  assign mu_class_o  = mu_sel ? l1_class : l0_class;
  assign mu_rd_o     = mu_sel ? l1_rd : l0_rd;
  assign lsu_rd_o    = lsu_sel ? l1_rd : l0_rd;
  assign lsu_addr_o  = lsu_sel ? l1_addr : l0_addr;

endmodule

`default_nettype wire

/* test/tb_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch;
  import dispatch_pkg::*;

  localparam int NUM_TESTS = 6;
  // random run dominates with at most three cycles per pair
  localparam int CYCLES_PER_TEST = 1000;
  localparam int RAND_PAIRS = 300;

  logic clk = 1'b0;
  logic resetn;
  logic lane0_v_i, lane1_v_i, branch_ex_i;
  op_class_t lane0_class_i, lane1_class_i;
  reg_idx_t lane0_rd_i, lane1_rd_i;
  word_t lane0_pc_i, lane0_imm_i, lane0_rs1_i, lane0_rs2_i;
  word_t lane1_pc_i, lane1_imm_i, lane1_rs1_i, lane1_rs2_i;
  byp_sel_t lane0_byp1_i, lane0_byp2_i, lane1_byp1_i, lane1_byp2_i;
  word_t rst_ex0_i, rst_ex1_i, rst_lsu_i;

  logic ex0_v_o, ex1_v_o, mu_v_o, ld_v_o, st_v_o;
  op_class_t ex0_class_o, ex1_class_o, mu_class_o;
  reg_idx_t ex0_rd_o, ex1_rd_o, mu_rd_o, lsu_rd_o;
  word_t ex0_op1_o, ex0_op2_o, ex1_op1_o, ex1_op2_o, mu_op1_o, mu_op2_o;
  word_t lsu_op1_o, lsu_op2_o, lsu_addr_o;
  uid_t ex0_uid_o, ex1_uid_o, mu_uid_o, lsu_uid_o;
  logic [1:0] uid_we_o;

  // expected d2 contents per lane
  logic e_v[2];
  op_class_t e_cls[2];
  reg_idx_t e_rd[2];
  word_t e_op1[2], e_op2[2], e_addr[2];
  byp_sel_t e_b1[2], e_b2[2];
  uid_t exp_uid = '0;
  logic [31:0] seed = 32'hd2b2d54e;

  dispatch_top uut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic byp_sel_t pick_sel(input logic [1:0] k);
    case (k)
      2'd1: return 3'b001;
      2'd2: return 3'b010;
      2'd3: return 3'b100;
      default: return 3'b000;
    endcase
  endfunction

  function automatic word_t forwarded(input byp_sel_t sel, input word_t op);
    case (sel)
      3'b001: return rst_ex0_i;
      3'b010: return rst_ex1_i;
      3'b100: return rst_lsu_i;
      default: return op;
    endcase
  endfunction

  function automatic bit to_lsu(input op_class_t c);
    return (c == CLS_LOAD) || (c == CLS_STORE);
  endfunction

  function automatic bit on_ex(input op_class_t c);
    return !to_lsu(c) && (c != CLS_MULDIV);
  endfunction

  function automatic bit has_class(input op_class_t c);
    return (e_v[0] && e_cls[0] == c) || (e_v[1] && e_cls[1] == c);
  endfunction

  function automatic bit writes_back(input bit l);
    return e_v[l] && e_cls[l] != CLS_STORE && e_cls[l] != CLS_BRANCH && e_rd[l] != 5'd0;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_idle();
    check("ex0_v_o", ex0_v_o, 0);
    check("ex1_v_o", ex1_v_o, 0);
    check("ld_v_o", ld_v_o, 0);
    check("st_v_o", st_v_o, 0);
    check("mu_v_o", mu_v_o, 0);
    check("uid_we_o", uid_we_o, 0);
  endtask

  task automatic check_unit(input string u, input bit l, input reg_idx_t rd, input word_t op1,
                            input word_t op2, input uid_t uid_got, input uid_t uid_exp);
    check({u, "_rd_o"}, rd, e_rd[l]);
    check({u, "_op1_o"}, op1, forwarded(e_b1[l], e_op1[l]));
    check({u, "_op2_o"}, op2, forwarded(e_b2[l], e_op2[l]));
    check({u, "_uid_o"}, uid_got, uid_exp);
  endtask

  // drives one lane with random data and records what d2 should hold
  task automatic set_lane(input bit l, input logic v, input op_class_t cls, input reg_idx_t rd,
                          input byp_sel_t b1, input byp_sel_t b2);
    word_t pc;
    word_t imm;
    word_t rs1;
    word_t rs2;
    pc = next_rand();
    imm = next_rand();
    rs1 = next_rand();
    rs2 = next_rand();
    e_v[l] = v;
    e_cls[l] = cls;
    e_rd[l] = rd;
    e_b1[l] = b1;
    e_b2[l] = b2;
    e_addr[l] = rs1 + imm;
    e_op1[l] = (cls == CLS_LUI) ? '0 : (cls == CLS_AUIPC) ? pc : rs1;
    e_op2[l] = (cls == CLS_ALU_IMM || cls == CLS_LOAD || cls == CLS_LUI ||
                cls == CLS_AUIPC) ? imm : rs2;
    if (l == 1'b0) begin
      lane0_v_i = v;
      lane0_class_i = cls;
      lane0_rd_i = rd;
      lane0_pc_i = pc;
      lane0_imm_i = imm;
      lane0_rs1_i = rs1;
      lane0_rs2_i = rs2;
      lane0_byp1_i = b1;
      lane0_byp2_i = b2;
    end else begin
      lane1_v_i = v;
      lane1_class_i = cls;
      lane1_rd_i = rd;
      lane1_pc_i = pc;
      lane1_imm_i = imm;
      lane1_rs1_i = rs1;
      lane1_rs2_i = rs2;
      lane1_byp1_i = b1;
      lane1_byp2_i = b2;
    end
  endtask

  // capture edge and then the d2 check
  // starts and ends 1 ns after a rising edge
  task automatic cycle_and_check(input logic flush);
    uid_t u0;
    uid_t u1;
    bit ml;
    bit mm;
    @(posedge clk);
    #1;
    // with a flush the pair offered now must never issue
    lane0_v_i = flush;
    lane1_v_i = flush;
    branch_ex_i = flush;
    rst_ex0_i = next_rand();
    rst_ex1_i = next_rand();
    rst_lsu_i = next_rand();
    @(negedge clk);
    if (flush) begin
      check_idle();
      @(posedge clk);
      #1;
      lane0_v_i = 1'b0;
      lane1_v_i = 1'b0;
      branch_ex_i = 1'b0;
      @(negedge clk);
      check_idle();
      check("ex0_uid_o", ex0_uid_o, exp_uid);
    end else begin
      ml = e_v[1] && to_lsu(e_cls[1]);
      mm = e_v[1] && (e_cls[1] == CLS_MULDIV);
      u0 = exp_uid;
      u1 = exp_uid + (e_v[0] ? 8'd1 : 8'd0);
      check("ex0_v_o", ex0_v_o, e_v[0] && on_ex(e_cls[0]));
      check("ex1_v_o", ex1_v_o, e_v[1] && on_ex(e_cls[1]));
      check("ld_v_o", ld_v_o, has_class(CLS_LOAD));
      check("st_v_o", st_v_o, has_class(CLS_STORE));
      check("mu_v_o", mu_v_o, has_class(CLS_MULDIV));
      check("uid_we_o", uid_we_o, {writes_back(1), writes_back(0)});
      if (e_v[0] && on_ex(e_cls[0])) begin
        check("ex0_class_o", ex0_class_o, e_cls[0]);
        check_unit("ex0", 0, ex0_rd_o, ex0_op1_o, ex0_op2_o, ex0_uid_o, u0);
      end
      if (e_v[1] && on_ex(e_cls[1])) begin
        check("ex1_class_o", ex1_class_o, e_cls[1]);
        check_unit("ex1", 1, ex1_rd_o, ex1_op1_o, ex1_op2_o, ex1_uid_o, u1);
      end
      // address is built for every class of the lane the lsu follows
      if (e_v[ml]) begin
        check("lsu_addr_o", lsu_addr_o, e_addr[ml]);
      end
      if (has_class(CLS_LOAD) || has_class(CLS_STORE)) begin
        check_unit("lsu", ml, lsu_rd_o, lsu_op1_o, lsu_op2_o, lsu_uid_o, ml ? u1 : u0);
      end
      if (has_class(CLS_MULDIV)) begin
        check("mu_class_o", mu_class_o, CLS_MULDIV);
        check_unit("mu", mm, mu_rd_o, mu_op1_o, mu_op2_o, mu_uid_o, mm ? u1 : u0);
      end
      exp_uid = exp_uid + (e_v[0] ? 8'd1 : 8'd0) + (e_v[1] ? 8'd1 : 8'd0);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_idle();
    check("ex0_uid_o", ex0_uid_o, 0);
    @(posedge clk);
    #1;
    set_lane(0, 1, CLS_ALU_REG, 5'd1, '0, '0);
    set_lane(1, 1, CLS_ALU_IMM, 5'd2, '0, '0);
    cycle_and_check(0);
  endtask

  task automatic test_operands();
    for (int c = 0; c < 8; c++) begin
      set_lane(0, 1, op_class_t'(c), 5'd3, '0, '0);
      set_lane(1, 0, CLS_ALU_REG, 5'd4, '0, '0);
      cycle_and_check(0);
      set_lane(0, 1, CLS_ALU_REG, 5'd5, '0, '0);
      set_lane(1, 1, op_class_t'(c), 5'd6, '0, '0);
      cycle_and_check(0);
    end
  endtask

  task automatic test_routing();
    set_lane(0, 1, CLS_MULDIV, 5'd7, '0, '0);
    set_lane(1, 1, CLS_LOAD, 5'd8, '0, '0);
    cycle_and_check(0);
    set_lane(0, 1, CLS_MULDIV, 5'd9, '0, '0);
    set_lane(1, 1, CLS_STORE, 5'd10, '0, '0);
    cycle_and_check(0);
    set_lane(0, 1, CLS_LOAD, 5'd11, '0, '0);
    set_lane(1, 1, CLS_MULDIV, 5'd12, '0, '0);
    cycle_and_check(0);
    set_lane(0, 1, CLS_ALU_IMM, 5'd13, '0, '0);
    set_lane(1, 1, CLS_AUIPC, 5'd14, '0, '0);
    cycle_and_check(0);
  endtask

  task automatic test_bypass();
    byp_sel_t s0;
    byp_sel_t s1;
    byp_sel_t s2;
    for (int i = 0; i < 3; i++) begin
      s0 = 3'b001 << i;
      s1 = 3'b001 << ((i + 1) % 3);
      s2 = 3'b001 << ((i + 2) % 3);
      set_lane(0, 1, CLS_ALU_REG, 5'd1, s0, s1);
      set_lane(1, 1, CLS_ALU_IMM, 5'd2, s2, s0);
      cycle_and_check(0);
      set_lane(0, 1, CLS_MULDIV, 5'd3, s1, s2);
      set_lane(1, 1, CLS_STORE, 5'd4, s0, s1);
      cycle_and_check(0);
    end
  endtask

  task automatic test_flush();
    set_lane(0, 1, CLS_ALU_REG, 5'd15, '0, '0);
    set_lane(1, 1, CLS_LOAD, 5'd16, '0, '0);
    cycle_and_check(1);
    set_lane(0, 1, CLS_ALU_IMM, 5'd17, '0, '0);
    set_lane(1, 1, CLS_MULDIV, 5'd18, '0, '0);
    cycle_and_check(0);
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [31:0] s;
    op_class_t c0;
    op_class_t c1;
    for (int n = 0; n < RAND_PAIRS; n++) begin
      r = next_rand();
      // low lcg bits repeat, so rd 0 and flush come from high bits
      s = next_rand();
      c0 = op_class_t'(r[31:29]);
      c1 = op_class_t'(r[28:26]);
      // one memory op and one muldiv per pair at most
      if (to_lsu(c0) && to_lsu(c1)) begin
        c1 = CLS_ALU_REG;
      end
      if (c0 == CLS_MULDIV && c1 == CLS_MULDIV) begin
        c1 = CLS_BRANCH;
      end
      set_lane(0, 1, c0, (s[31:30] == 2'd0) ? 5'd0 : r[25:21], pick_sel(r[20:19]),
               pick_sel(r[18:17]));
      set_lane(1, r[16] | r[15], c1, r[14:10], pick_sel(r[9:8]), pick_sel(r[7:6]));
      cycle_and_check(s[29:27] == 3'd0);
    end
  endtask

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * 20);
    $display("watchdog timeout, the tests did not finish in time");
    $display("Result: FAILED");
    $fatal(1);
  end

  initial begin
    resetn = 1'b0;
    branch_ex_i = 1'b0;
    rst_ex0_i = '0;
    rst_ex1_i = '0;
    rst_lsu_i = '0;
    set_lane(0, 0, CLS_ALU_REG, 5'd0, '0, '0);
    set_lane(1, 0, CLS_ALU_REG, 5'd0, '0, '0);
    repeat (16) @(posedge clk);
    #1;
    resetn = 1'b1;
    test_reset();
    test_operands();
    test_routing();
    test_bypass();
    test_flush();
    test_random();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hdl/dispatch_pkg.sv
hdl/lane_operand_reg.sv
hdl/issue_router.sv
hdl/bypass_mux.sv
hdl/uid_alloc.sv
hdl/dispatch_top.sv
test/tb_dispatch.sv
